/* dv/rvCoreTb.sv */
// Core testbench
module rvCoreTb;
	import rvIsaPkg::*;
	import rvPipePkg::*;

	localparam int MAX_TESTS  = 8;
	localparam int MAX_INSTR  = 32;
	localparam int MAX_STORES = 16;

	logic     clk;
	logic     rst_n;
	wordAddrT imemAddr;
	wordT     imemRdata;
	logic     imemStall;
	dmemReqT  dmemReq;
	wordT     dmemRdata;
	logic     dmemStall;
	integer   seed;

	wordT imem [256];
	wordT dmem [256];

	// ==============================
	// Test table
	// ==============================
	string    testName  [MAX_TESTS];
	bit       testStalls[MAX_TESTS];
	int       progLen   [MAX_TESTS];
	wordT     testProg  [MAX_TESTS][MAX_INSTR];
	int       nExp      [MAX_TESTS];
	wordAddrT expAddr   [MAX_TESTS][MAX_STORES];
	wordT     expData   [MAX_TESTS][MAX_STORES];
	int       nTests;
	int       cur;

	rvCore dut0 (
		.clk       (clk),
		.rst_n     (rst_n),
		.imemAddr  (imemAddr),
		.imemRdata (imemRdata),
		.imemStall (imemStall),
		.dmemReq   (dmemReq),
		.dmemRdata (dmemRdata),
		.dmemStall (dmemStall)
	);

	always #2 clk = ~clk;

	function automatic wordT encR(logic [6:0] f7, regAddrT rs2, regAddrT rs1,
		logic [2:0] f3, regAddrT rd);
		return {f7, rs2, rs1, f3, rd, OP};
	endfunction

	function automatic wordT encI(logic [11:0] imm, regAddrT rs1, logic [2:0] f3,
		regAddrT rd, opcodeT op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic wordT encS(logic [11:0] imm, regAddrT rs2, regAddrT rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], STORE};
	endfunction

	function automatic wordT encB(logic [12:0] imm, regAddrT rs2, regAddrT rs1,
		logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], BRANCH};
	endfunction

	function automatic wordT encJ(logic [20:0] imm, regAddrT rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, JAL};
	endfunction

	function automatic wordT fillWord(logic [7:0] a);
		return {8'hC3, a, ~a, a};
	endfunction

	// Memory models answer in the same cycle
	assign imemRdata = imem[imemAddr[7:0]];
	assign dmemRdata = dmemReq.read ? dmem[dmemReq.addr[7:0]] : '0;   // Only on a read request

	always @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 256; i++)
				dmem[i] <= fillWord(i[7:0]);
		end else if (dmemReq.write && !imemStall && !dmemStall) begin
			dmem[dmemReq.addr[7:0]] <= dmemReq.wdata;
		end
	end

	task automatic abortRun(string reason);
		$display("%s", reason);
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	task automatic checkStoreAddr(string name, wordAddrT expected, wordAddrT actual);
		if (expected !== actual)
			abortRun($sformatf("ERR %s store address: expected %h, actual %h",
				name, expected, actual));
	endtask

	task automatic checkStoreData(string name, wordT expected, wordT actual);
		if (expected !== actual)
			abortRun($sformatf("ERR %s store data: expected %h, actual %h",
				name, expected, actual));
	endtask

	task automatic startTest(string name, bit stalls);
		cur = nTests;
		nTests++;
		testName[cur]   = name;
		testStalls[cur] = stalls;
		progLen[cur]    = 0;
		nExp[cur]       = 0;
	endtask

	task automatic addInstr(wordT w);
		testProg[cur][progLen[cur]] = w;
		progLen[cur]++;
	endtask

	task automatic addStore(wordAddrT a, wordT d);
		expAddr[cur][nExp[cur]] = a;
		expData[cur][nExp[cur]] = d;
		nExp[cur]++;
	endtask

	task automatic buildTable();
		logic [3:0] aluSel [9];   // {funct7[5], funct3}
		wordT       aluExp [9];
		aluSel = '{4'b0000, 4'b1000, 4'b0111, 4'b0110, 4'b0100,
			4'b0010, 4'b0001, 4'b0101, 4'b1101};
		aluExp = '{32'hFFFF_FFF8, 32'hFFFF_FFEE, 32'h0000_0001, 32'hFFFF_FFF7,
			32'hFFFF_FFF6, 32'h0000_0001, 32'hFFFF_FE60, 32'h07FF_FFFF, 32'hFFFF_FFFF};
		nTests = 0;

		startTest("aluOps", 0);   // x1 = -13, x2 = 5
		addInstr(encI(12'hFF3, 0, 3'b000, 1, OPIMM));
		addInstr(encI(12'd5, 0, 3'b000, 2, OPIMM));
		for (int i = 0; i < 9; i++) begin
			addInstr(encR({1'b0, aluSel[i][3], 5'b0}, 2, 1, aluSel[i][2:0], 3 + i));
			addInstr(encS(12'(256 + 4 * i), 3 + i, 0));
			addStore(30'(64 + i), aluExp[i]);
		end
		addInstr(encI(12'h402, 1, 3'b101, 12, OPIMM));   // srai x12, x1, 2
		addInstr(encS(12'd292, 12, 0));
		addStore(30'd73, 32'hFFFF_FFFC);
		addInstr(encJ(21'd0, 0));

		startTest("forwarding", 0);
		addInstr(encI(12'd7, 0, 3'b000, 1, OPIMM));
		addInstr(encI(12'd3, 1, 3'b000, 2, OPIMM));
		addInstr(encR(7'd0, 1, 2, 3'b000, 3));   // x2 from MEM, x1 from WB
		addInstr(encR(7'd0, 3, 3, 3'b000, 4));
		addInstr(encS(12'd256, 4, 0));
		addInstr(encR(7'd0, 2, 4, 3'b000, 5));
		addInstr(encS(12'd260, 5, 0));
		addInstr(encI(12'd9, 0, 3'b000, 7, OPIMM));
		addInstr(encI(12'd2, 0, 3'b000, 8, OPIMM));
		addInstr(encR(7'd0, 8, 7, 3'b000, 9));
		addInstr(encS(12'd264, 9, 0));
		addInstr(encR(7'd0, 9, 9, 3'b000, 10));
		addInstr(encI(12'd0, 0, 3'b000, 11, OPIMM));
		addInstr(encS(12'd268, 10, 0));   // Store data from WB
		addInstr(encJ(21'd0, 0));
		addStore(30'd64, 32'd34);
		addStore(30'd65, 32'd44);
		addStore(30'd66, 32'd11);
		addStore(30'd67, 32'd22);

		startTest("loadUse", 0);
		addInstr(encI(12'd85, 0, 3'b000, 1, OPIMM));
		addInstr(encI(12'd100, 0, 3'b000, 4, OPIMM));
		addInstr(encS(12'd512, 1, 0));
		addInstr(encI(12'd512, 0, 3'b010, 2, LOAD));
		addInstr(encR(7'd0, 4, 2, 3'b000, 3));
		addInstr(encS(12'd516, 3, 0));
		addInstr(encI(12'd520, 0, 3'b010, 5, LOAD));   // Preloaded word
		addInstr(encI(12'd1, 5, 3'b000, 6, OPIMM));
		addInstr(encS(12'd524, 6, 0));
		addInstr(encI(12'd512, 0, 3'b010, 7, LOAD));
		addInstr(encS(12'd528, 7, 0));
		addInstr(encJ(21'd0, 0));
		addStore(30'd128, 32'd85);
		addStore(30'd129, 32'd185);
		addStore(30'd131, fillWord(8'd130) + 32'd1);
		addStore(30'd132, 32'd85);

		startTest("branches", 0);
		addInstr(encI(12'd3, 0, 3'b000, 1, OPIMM));
		addInstr(encI(12'd3, 0, 3'b000, 2, OPIMM));
		addInstr(encB(13'd8, 2, 1, 3'b000));   // beq taken
		addInstr(encS(12'd256, 1, 0));          // Skipped marker
		addInstr(encI(12'd7, 0, 3'b000, 3, OPIMM));
		addInstr(encB(13'd8, 2, 1, 3'b001));   // bne falls through
		addInstr(encS(12'd260, 3, 0));
		addInstr(encJ(21'd8, 4));               // Link is 32
		addInstr(encS(12'd300, 1, 0));
		addInstr(encS(12'd264, 4, 0));
		addInstr(encI(12'd1, 0, 3'b000, 5, OPIMM));
		addInstr(encB(13'd8, 0, 5, 3'b001));   // x5 still in flight
		addInstr(encS(12'd304, 1, 0));
		addInstr(encS(12'd272, 5, 0));
		addInstr(encJ(21'd0, 0));
		addStore(30'd65, 32'd7);
		addStore(30'd66, 32'd32);
		addStore(30'd68, 32'd1);

		startTest("forwardingStalls", 1);   // Same program and stores as test 2
		progLen[cur] = progLen[1];
		nExp[cur]    = nExp[1];
		testProg[cur] = testProg[1];
		expAddr[cur]  = expAddr[1];
		expData[cur]  = expData[1];
	endtask

	initial begin
		int got;
		int cycles;
		int watchdogCycles;
		clk       = 1'b0;
		rst_n     = 1'b0;
		imemStall = 1'b0;
		dmemStall = 1'b0;
		seed      = 32'h7fc3;
		buildTable();

		watchdogCycles = 16;
		for (int t = 0; t < nTests; t++)
			watchdogCycles += progLen[t] * 20 + 12;
		fork
			begin
				#(watchdogCycles * 4);
				abortRun($sformatf("Watchdog expired after %0d cycles", watchdogCycles));
			end
		join_none

		for (int t = 0; t < nTests; t++) begin
			rst_n     = 1'b0;
			imemStall = 1'b0;
			dmemStall = 1'b0;
			for (int i = 0; i < 256; i++)
				imem[i] = i < progLen[t] ? testProg[t][i] : encI(12'(i), 0, 3'b000, 0, OPIMM);
			repeat (10) @(negedge clk);
			rst_n  = 1'b1;
			got    = 0;
			cycles = 0;
			while (got < nExp[t] && cycles < progLen[t] * 20) begin
				@(negedge clk);
				if (testStalls[t]) begin
					imemStall = ($random(seed) & 3) == 0;
					dmemStall = ($random(seed) & 3) == 0;
				end
				// A store counts once, at the edge that accepts it
				if (dmemReq.write && !imemStall && !dmemStall) begin
					checkStoreAddr(testName[t], expAddr[t][got], dmemReq.addr);
					checkStoreData(testName[t], expData[t][got], dmemReq.wdata);
					got++;
				end
				cycles++;
			end
			if (got < nExp[t])
				abortRun($sformatf("Test %s ended after %0d cycles with %0d of %0d stores seen",
					testName[t], cycles, got, nExp[t]));
		end

		$display("Simulation PASSED");
		$finish;
	end

endmodule

/* dv/rvCore_assert.sv */
// Core memory port checks
module rvCoreAssert (
	input logic               clk,
	input logic               rst_n,
	input rvIsaPkg::wordAddrT imemAddr,
	input logic               imemStall,
	input rvPipePkg::dmemReqT dmemReq,
	input logic               dmemStall
);

	// A data request is either a load or a store
	assert property (@(posedge clk) disable iff (!rst_n)
		!(dmemReq.read && dmemReq.write))
		else $error("Data request has read and write high together");

	assert property (@(posedge clk) $rose(rst_n) |-> !dmemReq.read && !dmemReq.write)
		else $error("Data request active in the first cycle after reset");

	// Back-pressure freezes both ports
	assert property (@(posedge clk) disable iff (!rst_n)
		(imemStall || dmemStall) |=> $stable(imemAddr) && $stable(dmemReq))
		else $error("Memory port changed while a stall was high");

endmodule

bind rvCore rvCoreAssert assert0 (.*);

/* list.f */
rtl/rvIsaPkg.sv
rtl/rvPipePkg.sv
rtl/rvDecoder.sv
rtl/rvRegFile.sv
rtl/rvAlu.sv
rtl/rvHazardUnit.sv
rtl/rvCore.sv
dv/rvCore_assert.sv
dv/rvCoreTb.sv

/* rtl/rvAlu.sv */
// Integer ALU
module rvAlu (
	input  rvIsaPkg::wordT  a,
	input  rvIsaPkg::wordT  b,
	input  rvIsaPkg::aluOpT op,
	output rvIsaPkg::wordT  y
);
	import rvIsaPkg::*;

	logic [4:0] shamt;

	assign shamt = b[4:0];

	always_comb begin
		case (op)
			ALU_ADD: y = a + b;
			ALU_SUB: y = a - b;
			ALU_SLL: y = a << shamt;
			ALU_SLT: y = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
			ALU_XOR: y = a ^ b;
			ALU_SRL: y = a >> shamt;
			ALU_SRA: y = wordT'($signed(a) >>> shamt);   // Sign fill
			ALU_OR:  y = a | b;
			ALU_AND: y = a & b;
			default: y = a + b;
		endcase
	end

endmodule

/* rtl/rvCore.sv */
// Five-stage RISC-V core
module rvCore (
	input  logic               clk,
	input  logic               rst_n,
	output rvIsaPkg::wordAddrT imemAddr,
	input  rvIsaPkg::wordT     imemRdata,
	input  logic               imemStall,
	output rvPipePkg::dmemReqT dmemReq,
	input  rvIsaPkg::wordT     dmemRdata,
	input  logic               dmemStall
);
	import rvIsaPkg::*;
	import rvPipePkg::*;

	logic   hold;   // Memory back-pressure
	wordT   pc;
	ifIdT   ifId;
	idExT   idEx;
	idExT   idExNext;
	exMemT  exMem;
	memWbT  memWb;
	ctrlT   idCtrl;
	aluOpT  idAluOp;
	wordT   idImm;
	wordT   idRs1Data;
	wordT   idRs2Data;
	wordT   branchTarget;
	logic   regsEqual;
	logic   redirect;
	fwdSelT fwdA;
	fwdSelT fwdB;
	logic   stallFront;
	logic   bubble;
	wordT   memFwdData;
	wordT   opA;
	wordT   opB;
	wordT   aluB;
	wordT   aluResult;
	wordT   wbData;

	function automatic wordT fwdMux(fwdSelT sel, wordT regVal, wordT memVal, wordT wbVal);
		case (sel)
			FWD_FROM_MEM: return memVal;
			FWD_FROM_WB:  return wbVal;
			default:      return regVal;
		endcase
	endfunction

	assign hold = imemStall | dmemStall;

	// ==============================
	// Fetch
	// ==============================
	assign imemAddr = pc[XLEN-1:2];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc         <= '0;
			ifId.pc    <= '0;
			ifId.instr <= NOP_INSTR;
		end else if (!hold && !stallFront) begin
			pc         <= redirect ? branchTarget : pc + 32'd4;
			ifId.pc    <= pc;
			ifId.instr <= redirect ? NOP_INSTR : imemRdata;   // Squash wrong-path fetch
		end
	end

	// ==============================
	// Decode
	// ==============================
	rvDecoder decoder0 (.instr(ifId.instr), .ctrl(idCtrl), .aluOp(idAluOp), .imm(idImm));

	rvRegFile regFile0 (
		.clk     (clk),
		.rst_n   (rst_n),
		.rs1     (ifId.instr.r.rs1),
		.rs2     (ifId.instr.r.rs2),
		.wrEn    (memWb.regWrite && !hold),
		.wrAddr  (memWb.rd),
		.wrData  (wbData),
		.rs1Data (idRs1Data),
		.rs2Data (idRs2Data)
	);

	assign regsEqual    = idRs1Data == idRs2Data;
	assign branchTarget = ifId.pc + idImm;
	// No redirect while sources are still in flight
	assign redirect = !stallFront && (idCtrl.isJal ||
		(idCtrl.branchEq && regsEqual) || (idCtrl.branchNe && !regsEqual));

	rvHazardUnit hazard0 (
		.idInstr    (ifId.instr),
		.idEx       (idEx),
		.exMem      (exMem),
		.memWb      (memWb),
		.fwdA       (fwdA),
		.fwdB       (fwdB),
		.stallFront (stallFront),
		.bubble     (bubble)
	);

	always_comb begin
		idExNext.ctrl = idCtrl;
		if (bubble)
			idExNext.ctrl = '0;
		idExNext.aluOp   = idAluOp;
		idExNext.rs1     = ifId.instr.r.rs1;
		idExNext.rs2     = ifId.instr.r.rs2;
		idExNext.rd      = ifId.instr.r.rd;
		idExNext.rs1Data = idRs1Data;
		idExNext.rs2Data = idRs2Data;
		idExNext.imm     = idImm;
		idExNext.pcPlus4 = ifId.pc + 32'd4;   // Link value for jal
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			idEx <= '0;
		else if (!hold)
			idEx <= idExNext;
	end

	// ==============================
	// Execute
	// ==============================
	assign memFwdData = exMem.ctrl.isJal ? exMem.pcPlus4 : exMem.aluResult;
	assign opA  = fwdMux(fwdA, idEx.rs1Data, memFwdData, wbData);
	assign opB  = fwdMux(fwdB, idEx.rs2Data, memFwdData, wbData);
	assign aluB = idEx.ctrl.aluSrc ? idEx.imm : opB;

	rvAlu alu0 (.a(opA), .b(aluB), .op(idEx.aluOp), .y(aluResult));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			exMem <= '0;
		end else if (!hold) begin
			exMem.ctrl      <= idEx.ctrl;
			exMem.rd        <= idEx.rd;
			exMem.aluResult <= aluResult;
			exMem.storeData <= opB;   // Forwarded rs2
			exMem.pcPlus4   <= idEx.pcPlus4;
		end
	end

	// ==============================
	// Memory and writeback
	// ==============================
	assign dmemReq.read  = exMem.ctrl.memRead;
	assign dmemReq.write = exMem.ctrl.memWrite;
	assign dmemReq.addr  = exMem.aluResult[XLEN-1:2];
	assign dmemReq.wdata = exMem.storeData;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			memWb <= '0;
		end else if (!hold) begin
			memWb.regWrite  <= exMem.ctrl.regWrite;
			memWb.memToReg  <= exMem.ctrl.memToReg;
			memWb.isJal     <= exMem.ctrl.isJal;
			memWb.rd        <= exMem.rd;
			memWb.aluResult <= exMem.aluResult;
			memWb.loadData  <= dmemRdata;
			memWb.pcPlus4   <= exMem.pcPlus4;
		end
	end

	assign wbData = memWb.isJal ? memWb.pcPlus4 :
		memWb.memToReg ? memWb.loadData : memWb.aluResult;

endmodule

/* rtl/rvDecoder.sv */
// Instruction decoder
module rvDecoder (
	input  rvIsaPkg::instrT instr,
	output rvPipePkg::ctrlT ctrl,
	output rvIsaPkg::aluOpT aluOp,
	output rvIsaPkg::wordT  imm
);
	import rvIsaPkg::*;

	wordT immI;
	wordT immShamt;
	wordT immS;
	wordT immB;
	wordT immJ;
	logic isShift;
	logic isSrai;

	// I and J fields come from the R view
	assign immI     = {{20{instr.r.funct7[6]}}, instr.r.funct7, instr.r.rs2};
	assign immShamt = {27'b0, instr.r.rs2};
	assign immJ     = {{12{instr.r.funct7[6]}}, instr.r.rs1, instr.r.funct3, instr.r.rs2[0],
		instr.r.funct7[5:0], instr.r.rs2[4:1], 1'b0};

	// S and B fields come from the split view
	assign immS = {{20{instr.sb.immHi[6]}}, instr.sb.immHi, instr.sb.immLo};
	assign immB = {{20{instr.sb.immHi[6]}}, instr.sb.immLo[0], instr.sb.immHi[5:0],
		instr.sb.immLo[4:1], 1'b0};

	assign isShift = instr.r.funct3[1:0] == 2'b01;   // slli, srli, srai
	assign isSrai  = instr.r.funct3 == 3'b101 && instr.r.funct7[5];

	always_comb begin
		ctrl  = '0;
		aluOp = ALU_ADD;   // Address and link paths just add
		imm   = immI;
		case (instr.r.opcode)
			OP: begin
				ctrl.regWrite = 1'b1;
				aluOp = aluOpT'({instr.r.funct7[5], instr.r.funct3});
			end
			OPIMM: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc   = 1'b1;
				imm   = isShift ? immShamt : immI;
				aluOp = aluOpT'({isSrai, instr.r.funct3});
			end
			LOAD: begin
				ctrl.regWrite = 1'b1;
				ctrl.memRead  = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.aluSrc   = 1'b1;
			end
			STORE: begin
				ctrl.memWrite = 1'b1;
				ctrl.aluSrc   = 1'b1;
				imm = immS;
			end
			BRANCH: begin
				ctrl.branchEq = instr.r.funct3 == 3'b000;
				ctrl.branchNe = instr.r.funct3 == 3'b001;
				imm = immB;
			end
			JAL: begin
				ctrl.regWrite = 1'b1;
				ctrl.isJal    = 1'b1;
				imm = immJ;
			end
			default: begin
				ctrl = '0;   // Unsupported opcode acts as a NOP
			end
		endcase
	end

endmodule

/* rtl/rvHazardUnit.sv */
// Forwarding and stall control
module rvHazardUnit (
	input  rvIsaPkg::instrT   idInstr,
	input  rvPipePkg::idExT   idEx,
	input  rvPipePkg::exMemT  exMem,
	input  rvPipePkg::memWbT  memWb,
	output rvPipePkg::fwdSelT fwdA,
	output rvPipePkg::fwdSelT fwdB,
	output logic              stallFront,
	output logic              bubble
);
	import rvIsaPkg::*;
	import rvPipePkg::*;

	regAddrT idRs1;
	regAddrT idRs2;
	logic    exWrites;
	logic    memWrites;
	logic    wbWrites;
	logic    loadUse;
	logic    branchSrc;

	// Newest producer wins
	function automatic fwdSelT pickFwd(regAddrT rs, regAddrT memRd, logic memW,
		regAddrT wbRd, logic wbW);
		if (memW && memRd == rs)
			return FWD_FROM_MEM;
		if (wbW && wbRd == rs)
			return FWD_FROM_WB;
		return FWD_NONE;
	endfunction

	assign idRs1 = idInstr.r.rs1;
	assign idRs2 = idInstr.r.rs2;

	assign exWrites  = idEx.ctrl.regWrite && idEx.rd != '0;
	assign memWrites = exMem.ctrl.regWrite && exMem.rd != '0;
	assign wbWrites  = memWb.regWrite && memWb.rd != '0;

	assign fwdA = pickFwd(idEx.rs1, exMem.rd, memWrites, memWb.rd, wbWrites);
	assign fwdB = pickFwd(idEx.rs2, exMem.rd, memWrites, memWb.rd, wbWrites);

	// Load data is not ready until writeback
	assign loadUse = idEx.ctrl.memRead && idEx.rd != '0 &&
		(idEx.rd == idRs1 || idEx.rd == idRs2);

	// Branch compares in decode, so producers in EX or MEM must drain first
	assign branchSrc = idInstr.r.opcode == BRANCH &&
		((exWrites && (idEx.rd == idRs1 || idEx.rd == idRs2)) ||
		 (memWrites && (exMem.rd == idRs1 || exMem.rd == idRs2)));

	assign stallFront = loadUse || branchSrc;
	assign bubble     = loadUse || branchSrc;

endmodule

/* rtl/rvIsaPkg.sv */
// RISC-V integer ISA definitions
package rvIsaPkg;

	localparam int XLEN = 32;

	typedef logic [XLEN-1:0] wordT;
	typedef logic [4:0]      regAddrT;
	typedef logic [XLEN-3:0] wordAddrT;   // Byte address minus the low two bits

	typedef enum logic [6:0] {
		OP     = 7'b0110011,
		OPIMM  = 7'b0010011,
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011,
		BRANCH = 7'b1100011,
		JAL    = 7'b1101111
	} opcodeT;

	// Same bits as {funct7[5], funct3} of a register op
	typedef enum logic [3:0] {
		ALU_ADD = 4'b0000,
		ALU_SUB = 4'b1000,
		ALU_SLL = 4'b0001,
		ALU_SLT = 4'b0010,
		ALU_XOR = 4'b0100,
		ALU_SRL = 4'b0101,
		ALU_SRA = 4'b1101,
		ALU_OR  = 4'b0110,
		ALU_AND = 4'b0111
	} aluOpT;

	typedef struct packed {
		logic [6:0] funct7;
		regAddrT    rs2;
		regAddrT    rs1;
		logic [2:0] funct3;
		regAddrT    rd;
		opcodeT     opcode;
	} rViewT;

	// Store and branch split their immediate around rs1/rs2
	typedef struct packed {
		logic [6:0] immHi;
		regAddrT    rs2;
		regAddrT    rs1;
		logic [2:0] funct3;
		logic [4:0] immLo;
		opcodeT     opcode;
	} sbViewT;

	typedef union packed {
		rViewT  r;
		sbViewT sb;
	} instrT;

	localparam wordT NOP_INSTR = 32'h0000_0013;   // addi x0, x0, 0

endpackage

/* rtl/rvPipePkg.sv */
// Pipeline register and port types
package rvPipePkg;
	import rvIsaPkg::*;

	typedef struct packed {
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic memToReg;
		logic aluSrc;     // Immediate as second operand
		logic isJal;
		logic branchEq;
		logic branchNe;
	} ctrlT;

	typedef struct packed {
		wordT  pc;
		instrT instr;
	} ifIdT;

	typedef struct packed {
		ctrlT    ctrl;
		aluOpT   aluOp;
		regAddrT rs1;
		regAddrT rs2;
		regAddrT rd;
		wordT    rs1Data;
		wordT    rs2Data;
		wordT    imm;
		wordT    pcPlus4;
	} idExT;

	typedef struct packed {
		ctrlT    ctrl;
		regAddrT rd;
		wordT    aluResult;
		wordT    storeData;
		wordT    pcPlus4;
	} exMemT;

	// Only what writeback still needs
	typedef struct packed {
		logic    regWrite;
		logic    memToReg;
		logic    isJal;
		regAddrT rd;
		wordT    aluResult;
		wordT    loadData;
		wordT    pcPlus4;
	} memWbT;

	typedef struct packed {
		logic     read;
		logic     write;
		wordAddrT addr;
		wordT     wdata;
	} dmemReqT;

	typedef enum logic [1:0] {
		FWD_NONE     = 2'd0,
		FWD_FROM_MEM = 2'd1,
		FWD_FROM_WB  = 2'd2
	} fwdSelT;

endpackage

/* rtl/rvRegFile.sv */
// Register file with write-through
module rvRegFile (
	input  logic              clk,
	input  logic              rst_n,
	input  rvIsaPkg::regAddrT rs1,
	input  rvIsaPkg::regAddrT rs2,
	input  logic              wrEn,
	input  rvIsaPkg::regAddrT wrAddr,
	input  rvIsaPkg::wordT    wrData,
	output rvIsaPkg::wordT    rs1Data,
	output rvIsaPkg::wordT    rs2Data
);
	import rvIsaPkg::*;

	wordT regs [1:31];   // x0 has no storage

	function automatic wordT readPort(regAddrT addr);
		if (addr == '0)
			return '0;
		if (wrEn && wrAddr == addr)
			return wrData;   // Writeback bypass
		return regs[addr];
	endfunction

	always_comb begin
		rs1Data = readPort(rs1);
		rs2Data = readPort(rs2);
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (wrEn && wrAddr != '0) begin
			regs[wrAddr] <= wrData;
		end
	end

endmodule
